//--- all.f
+incdir+include
verilog/mdu_pkg.sv
verilog/mdu_mul_fast.sv
verilog/mdu_div.sv
verilog/mdu_top.sv
sim/tb_mdu.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mdu -o tb_mdu

# The log decides the outcome, so a failing run must not stop the script here
./obj_dir/tb_mdu > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
echo "Run did not pass, see sim.log"
exit 1

//--- include/mdu_ref_model.svh
`ifndef MDU_REF_MODEL_SVH
`define MDU_REF_MODEL_SVH

// Full 128-bit product, each operand widened by its own signedness
function automatic logic [63:0] model_mul(input mdu_pkg::mul_op_e op, input logic word,
                                          input logic [63:0] a, input logic [63:0] b);
  logic         a_signed;
  logic         b_signed;
  logic [127:0] a_wide;
  logic [127:0] b_wide;
  logic [127:0] prod;
  a_signed = op != mdu_pkg::MUL_OP_MULHU;
  b_signed = (op == mdu_pkg::MUL_OP_MUL) || (op == mdu_pkg::MUL_OP_MULH);
  a_wide   = {{64{a_signed & a[63]}}, a};
  b_wide   = {{64{b_signed & b[63]}}, b};
  prod     = a_wide * b_wide;
  if (word) begin
    return {{32{prod[31]}}, prod[31:0]};
  end
  if (op == mdu_pkg::MUL_OP_MUL) begin
    return prod[63:0];
  end
  return prod[127:64];
endfunction

// Operand as seen by a 32-bit form
function automatic logic [63:0] widen_operand(input logic [63:0] v, input logic word,
                                              input logic is_signed);
  if (!word) begin
    return v;
  end
  return {{32{is_signed & v[31]}}, v[31:0]};
endfunction

// Divide by zero or most negative over -1
function automatic logic div_is_special(input mdu_pkg::div_op_e op, input logic word,
                                        input logic [63:0] a, input logic [63:0] b);
  logic        is_signed;
  logic [63:0] x;
  logic [63:0] y;
  logic [63:0] most_neg;
  is_signed = (op == mdu_pkg::DIV_OP_DIV) || (op == mdu_pkg::DIV_OP_REM);
  x         = widen_operand(a, word, is_signed);
  y         = widen_operand(b, word, is_signed);
  most_neg  = word ? 64'hFFFF_FFFF_8000_0000 : 64'h8000_0000_0000_0000;
  return (y == 64'd0) || (is_signed && (x == most_neg) && (y == '1));
endfunction

function automatic logic [63:0] model_div(input mdu_pkg::div_op_e op, input logic word,
                                          input logic [63:0] a, input logic [63:0] b);
  logic        is_signed;
  logic        is_rem;
  logic [63:0] x;
  logic [63:0] y;
  logic [63:0] quo;
  logic [63:0] rem;
  logic [63:0] res;
  is_signed = (op == mdu_pkg::DIV_OP_DIV) || (op == mdu_pkg::DIV_OP_REM);
  is_rem    = (op == mdu_pkg::DIV_OP_REM) || (op == mdu_pkg::DIV_OP_REMU);
  x         = widen_operand(a, word, is_signed);
  y         = widen_operand(b, word, is_signed);
  if (y == 64'd0) begin
    quo = '1;
    rem = x;
  end else if (div_is_special(op, word, a, b)) begin
    quo = x;
    rem = 64'd0;
  end else if (is_signed) begin
    // Truncates toward zero, remainder follows the dividend
    quo = $signed(x) / $signed(y);
    rem = $signed(x) % $signed(y);
  end else begin
    quo = x / y;
    rem = x % y;
  end
  res = is_rem ? rem : quo;
  if (word) begin
    res = {{32{res[31]}}, res[31:0]};
  end
  return res;
endfunction

function automatic logic [63:0] model_result(input mdu_pkg::mdu_op_e op, input logic word,
                                             input logic [63:0] a, input logic [63:0] b);
  if (op[2]) begin
    return model_div(mdu_pkg::div_op_e'(op[1:0]), word, a, b);
  end
  return model_mul(mdu_pkg::mul_op_e'(op[1:0]), word, a, b);
endfunction

// Edges from acceptance to the response cycle
function automatic int model_latency(input mdu_pkg::mdu_op_e op, input logic word,
                                     input logic [63:0] a, input logic [63:0] b);
  if (!op[2]) begin
    if (word) begin
      return 2;
    end
    return (op == mdu_pkg::MDU_MUL) ? 4 : 5;
  end
  if (div_is_special(mdu_pkg::div_op_e'(op[1:0]), word, a, b)) begin
    return 1;
  end
  return word ? 33 : 65;
endfunction

`endif

//--- sim/tb_mdu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mdu;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_CORNER = 8;
  localparam int NUM_RANDOM = 20;
  localparam int NUM_FORMS  = 13;
  localparam int NUM_TESTS  = NUM_FORMS * (NUM_CORNER * NUM_CORNER + NUM_RANDOM);
  localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * 70 * CLK_PERIOD + 10 * CLK_PERIOD;

  `include "mdu_ref_model.svh"

  logic             clk_i;
  logic             rst_ni;
  logic [63:0]      operand_a_i;
  logic [63:0]      operand_b_i;
  mdu_pkg::mdu_op_e req_op_i;
  logic             req_word_i;
  logic             req_valid_i;
  logic             req_ready_o;
  logic             resp_valid_o;
  logic [63:0]      resp_value_o;

  int               seed = 51;
  int               cycle = 0;
  int               tests_done = 0;
  logic [63:0]      corner [NUM_CORNER];

  // Request in flight as captured at acceptance
  logic             pending = 1'b0;
  int               accept_cycle;
  int               exp_latency;
  logic [63:0]      exp_value;
  mdu_pkg::mdu_op_e sent_op;
  logic             sent_word;
  logic [63:0]      sent_a;
  logic [63:0]      sent_b;

  mdu_top dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (req_op_i),
    .req_word_i   (req_word_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_value_o (resp_value_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  task automatic report_error(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  // Handshake and response monitor, mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (pending) begin
        assert (req_ready_o == resp_valid_o)
          else report_error($sformatf("req_ready_o=%b resp_valid_o=%b while busy",
                                      req_ready_o, resp_valid_o));
        if (resp_valid_o) begin
          assert (cycle - accept_cycle == exp_latency)
            else report_error($sformatf("%s word=%b latency %0d, expected %0d",
                                        sent_op.name(), sent_word,
                                        cycle - accept_cycle, exp_latency));
          assert (resp_value_o == exp_value)
            else report_error($sformatf("%s word=%b a=%h b=%h got %h expected %h",
                                        sent_op.name(), sent_word, sent_a, sent_b,
                                        resp_value_o, exp_value));
          pending = 1'b0;
          tests_done++;
        end
      end else begin
        assert (req_ready_o && !resp_valid_o)
          else report_error("unit busy or responding with no request outstanding");
      end
      // Accepted at the coming rising edge
      if (req_valid_i && req_ready_o) begin
        pending      = 1'b1;
        accept_cycle = cycle + 1;
        sent_op      = req_op_i;
        sent_word    = req_word_i;
        sent_a       = operand_a_i;
        sent_b       = operand_b_i;
        exp_value    = model_result(req_op_i, req_word_i, operand_a_i, operand_b_i);
        exp_latency  = model_latency(req_op_i, req_word_i, operand_a_i, operand_b_i);
      end
    end
  end

  task automatic issue(input mdu_pkg::mdu_op_e op, input logic word,
                       input logic [63:0] a, input logic [63:0] b);
    @(posedge clk_i);
    while (pending) begin
      @(posedge clk_i);
    end
    #2;
    req_op_i    = op;
    req_word_i  = word;
    operand_a_i = a;
    operand_b_i = b;
    req_valid_i = 1'b1;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
  endtask

  task automatic run_form(input mdu_pkg::mdu_op_e op, input logic word);
    int          i;
    int          j;
    int          k;
    logic [63:0] a;
    logic [63:0] b;
    for (i = 0; i < NUM_CORNER; i++) begin
      for (j = 0; j < NUM_CORNER; j++) begin
        issue(op, word, corner[i], corner[j]);
      end
    end
    for (k = 0; k < NUM_RANDOM; k++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      // Smaller divisors give longer quotients
      if (k % 2 == 1) begin
        b = b >> (k * 3);
      end
      issue(op, word, a, b);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the tests did not finish in time");
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout");
  end

  initial begin
    mdu_pkg::mdu_op_e op;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = mdu_pkg::MDU_MUL;
    req_word_i  = 1'b0;
    operand_a_i = 64'd0;
    operand_b_i = 64'd0;
    corner[0] = 64'd0;
    corner[1] = 64'd1;
    corner[2] = 64'hFFFF_FFFF_FFFF_FFFF;
    corner[3] = 64'h8000_0000_0000_0000;
    corner[4] = 64'hFFFF_FFFF_8000_0000;
    corner[5] = 64'h0000_0000_8000_0000;
    corner[6] = 64'h0000_0000_FFFF_FFFF;
    corner[7] = 64'h7FFF_FFFF_FFFF_FFFF;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int n = 0; n < 8; n++) begin
      op = mdu_pkg::mdu_op_e'(n[2:0]);
      run_form(op, 1'b0);
      // Word forms exist for MUL and all divides
      if (op[2] || op == mdu_pkg::MDU_MUL) begin
        run_form(op, 1'b1);
      end
    end

    @(posedge clk_i);
    while (pending) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    if (tests_done == NUM_TESTS) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Only %0d of %0d responses were seen", tests_done, NUM_TESTS);
      $display("SIMULATION FAILED");
      $fatal(1, "Missing responses");
    end
  end

endmodule

`default_nettype wire

//--- verilog/mdu_div.sv
`timescale 1ns/100ps
`default_nettype none

module mdu_div (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [63:0]      operand_a_i,
  input  logic [63:0]      operand_b_i,
  input  mdu_pkg::div_op_e req_op_i,
  input  logic             req_word_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  output logic             resp_valid_o,
  output logic [63:0]      resp_value_o
);

  typedef enum logic [1:0] {
    StateIdle,
    StateDivide,
    StateFinish
  } state_e;

  state_e state_q, state_d;
  logic [5:0]  iter_q, iter_d;

  logic        op_rem_q, op_rem_d;
  logic        op_word_q, op_word_d;
  logic        neg_quo_q, neg_quo_d;
  logic        neg_rem_q, neg_rem_d;
  logic [63:0] divisor_q, divisor_d;
  logic [63:0] quo_q, quo_d;
  logic [63:0] rem_q, rem_d;

  // Request decode
  logic        op_signed;
  logic [63:0] a_ext, b_ext;
  logic        a_neg, b_neg;
  logic [63:0] a_abs, b_abs;
  logic        div_zero, div_ovf;

  logic [64:0] rem_shift;
  logic [64:0] rem_diff;

  logic [63:0] quo_fix, rem_fix, res;

  logic        o_valid_d;
  logic [63:0] o_value_d;

  assign req_ready_o = state_q == StateIdle;

  always_comb begin
    op_signed = ~req_op_i[0];
    a_ext = req_word_i ? {{32{op_signed & operand_a_i[31]}}, operand_a_i[31:0]} : operand_a_i;
    b_ext = req_word_i ? {{32{op_signed & operand_b_i[31]}}, operand_b_i[31:0]} : operand_b_i;
    a_neg = op_signed & a_ext[63];
    b_neg = op_signed & b_ext[63];
    a_abs = a_neg ? -a_ext : a_ext;
    b_abs = b_neg ? -b_ext : b_ext;
    div_zero = b_ext == '0;
    // Most negative value over -1
    div_ovf = op_signed && (&b_ext) &&
              a_ext == (req_word_i ? {{33{1'b1}}, 31'b0} : {1'b1, 63'b0});
  end

  // One restoring step per cycle
  assign rem_shift = {rem_q, quo_q[63]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};

  always_comb begin
    quo_fix = neg_quo_q ? -quo_q : quo_q;
    rem_fix = neg_rem_q ? -rem_q : rem_q;
    res     = op_rem_q ? rem_fix : quo_fix;
  end

  always_comb begin
    state_d   = state_q;
    iter_d    = iter_q;
    op_rem_d  = op_rem_q;
    op_word_d = op_word_q;
    neg_quo_d = neg_quo_q;
    neg_rem_d = neg_rem_q;
    divisor_d = divisor_q;
    quo_d     = quo_q;
    rem_d     = rem_q;
    o_valid_d = 1'b0;
    o_value_d = resp_value_o;

    unique case (state_q)
      StateIdle: begin
        if (req_valid_i) begin
          op_rem_d  = req_op_i[1];
          op_word_d = req_word_i;
          divisor_d = b_abs;
          iter_d    = req_word_i ? 6'd31 : 6'd63;
          neg_quo_d = 1'b0;
          neg_rem_d = 1'b0;
          if (div_zero) begin
            quo_d   = '1;
            rem_d   = a_ext;
            state_d = StateFinish;
          end else if (div_ovf) begin
            quo_d   = a_ext;
            rem_d   = '0;
            state_d = StateFinish;
          end else begin
            // Word dividend starts at the top so 32 shifts bring it through
            quo_d     = req_word_i ? {a_abs[31:0], 32'b0} : a_abs;
            rem_d     = '0;
            neg_quo_d = a_neg ^ b_neg;
            neg_rem_d = a_neg;
            state_d   = StateDivide;
          end
        end
      end

      StateDivide: begin
        if (!rem_diff[64]) begin
          rem_d = rem_diff[63:0];
          quo_d = {quo_q[62:0], 1'b1};
        end else begin
          rem_d = rem_shift[63:0];
          quo_d = {quo_q[62:0], 1'b0};
        end
        iter_d = iter_q - 6'd1;
        if (iter_q == 6'd0) begin
          state_d = StateFinish;
        end
      end

      StateFinish: begin
        o_valid_d = 1'b1;
        o_value_d = op_word_q ? {{32{res[31]}}, res[31:0]} : res;
        state_d   = StateIdle;
      end

      default: begin
        state_d = StateIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= StateIdle;
      iter_q       <= 6'd0;
      resp_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      iter_q       <= iter_d;
      resp_valid_o <= o_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    op_rem_q     <= op_rem_d;
    op_word_q    <= op_word_d;
    neg_quo_q    <= neg_quo_d;
    neg_rem_q    <= neg_rem_d;
    divisor_q    <= divisor_d;
    quo_q        <= quo_d;
    rem_q        <= rem_d;
    resp_value_o <= o_value_d;
  end

endmodule

`default_nettype wire

//--- verilog/mdu_mul_fast.sv
`timescale 1ns/100ps
`default_nettype none

module mdu_mul_fast (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [63:0]      operand_a_i,
  input  logic [63:0]      operand_b_i,
  input  mdu_pkg::mul_op_e req_op_i,
  input  logic             req_word_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  output logic             resp_valid_o,
  output logic [63:0]      resp_value_o
);

  typedef enum logic {
    StateIdle,
    StateProgress
  } state_e;

  state_e state_q, state_d;

  // Operands widened to 65 bits so each partial product is a signed 33x33
  logic [64:0] a_q, a_d;
  logic [64:0] b_q, b_d;
  logic        op_low_q, op_low_d;
  logic        op_word_q, op_word_d;

  // Steps lo*lo, hi*lo, lo*hi, hi*hi; bit 0 picks the A half, bit 1 the B half
  logic [1:0]  sel_step_q, sel_step_d;
  logic [1:0]  mac_step_q, mac_step_d;
  logic        mac_vld_q, mac_vld_d;
  logic [32:0] mac_a_q, mac_a_d;
  logic [32:0] mac_b_q, mac_b_d;

  logic [65:0] accum_q, accum_d;
  logic [65:0] mac_prod;

  logic        o_valid_d;
  logic [63:0] o_value_d;

  assign req_ready_o = state_q == StateIdle;

  assign mac_prod = $signed(accum_q) + $signed(mac_a_q) * $signed(mac_b_q);

  always_comb begin
    state_d    = state_q;
    a_d        = a_q;
    b_d        = b_q;
    op_low_d   = op_low_q;
    op_word_d  = op_word_q;
    sel_step_d = sel_step_q;
    mac_step_d = mac_step_q;
    mac_vld_d  = 1'b0;
    mac_a_d    = mac_a_q;
    mac_b_d    = mac_b_q;
    accum_d    = accum_q;
    o_valid_d  = 1'b0;
    o_value_d  = resp_value_o;

    unique case (state_q)
      StateIdle: begin
        if (req_valid_i) begin
          a_d = {(req_op_i != mdu_pkg::MUL_OP_MULHU) & operand_a_i[63], operand_a_i};
          b_d = {~req_op_i[1] & operand_b_i[63], operand_b_i};
          op_low_d   = req_op_i == mdu_pkg::MUL_OP_MUL;
          op_word_d  = req_word_i;
          sel_step_d = 2'd0;
          accum_d    = '0;
          state_d    = StateProgress;
        end
      end

      StateProgress: begin
        // Operand select runs one step ahead of the multiply-accumulate
        mac_a_d    = sel_step_q[0] ? a_q[64:32] : {1'b0, a_q[31:0]};
        mac_b_d    = sel_step_q[1] ? b_q[64:32] : {1'b0, b_q[31:0]};
        mac_step_d = sel_step_q;
        mac_vld_d  = 1'b1;
        sel_step_d = sel_step_q + 2'd1;

        if (mac_vld_q) begin
          unique case (mac_step_q)
            2'd0: begin
              o_value_d = {{32{mac_prod[31]}}, mac_prod[31:0]};
              accum_d   = {{32{mac_prod[65]}}, mac_prod[65:32]};
              // Word forms only need the low partial product
              if (op_word_q) begin
                o_valid_d = 1'b1;
                state_d   = StateIdle;
              end
            end
            2'd1: begin
              accum_d = mac_prod;
            end
            2'd2: begin
              o_value_d[63:32] = mac_prod[31:0];
              accum_d          = {{32{mac_prod[65]}}, mac_prod[65:32]};
              if (op_low_q) begin
                o_valid_d = 1'b1;
                state_d   = StateIdle;
              end
            end
            default: begin
              o_value_d = mac_prod[63:0];
              o_valid_d = 1'b1;
              state_d   = StateIdle;
            end
          endcase
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= StateIdle;
      sel_step_q   <= 2'd0;
      mac_vld_q    <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      sel_step_q   <= sel_step_d;
      mac_vld_q    <= mac_vld_d;
      resp_valid_o <= o_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    a_q          <= a_d;
    b_q          <= b_d;
    op_low_q     <= op_low_d;
    op_word_q    <= op_word_d;
    mac_step_q   <= mac_step_d;
    mac_a_q      <= mac_a_d;
    mac_b_q      <= mac_b_d;
    accum_q      <= accum_d;
    resp_value_o <= o_value_d;
  end

endmodule

`default_nettype wire

//--- verilog/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

  // External operation, bit 2 selects the divider
  typedef enum logic [2:0] {
    MDU_MUL    = 3'd0,
    MDU_MULH   = 3'd1,
    MDU_MULHSU = 3'd2,
    MDU_MULHU  = 3'd3,
    MDU_DIV    = 3'd4,
    MDU_DIVU   = 3'd5,
    MDU_REM    = 3'd6,
    MDU_REMU   = 3'd7
  } mdu_op_e;

  // Bit 1 clear means operand B is signed
  typedef enum logic [1:0] {
    MUL_OP_MUL    = 2'd0,
    MUL_OP_MULH   = 2'd1,
    MUL_OP_MULHSU = 2'd2,
    MUL_OP_MULHU  = 2'd3
  } mul_op_e;

  // Bit 0 set for unsigned, bit 1 set for remainder
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'd0,
    DIV_OP_DIVU = 2'd1,
    DIV_OP_REM  = 2'd2,
    DIV_OP_REMU = 2'd3
  } div_op_e;

endpackage

`default_nettype wire

//--- verilog/mdu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mdu_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [63:0]      operand_a_i,
  input  logic [63:0]      operand_b_i,
  input  mdu_pkg::mdu_op_e req_op_i,
  input  logic             req_word_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  output logic             resp_valid_o,
  output logic [63:0]      resp_value_o
);

  logic             is_div;
  mdu_pkg::mul_op_e mul_op;
  mdu_pkg::div_op_e div_op;

  logic        mul_req_valid, div_req_valid;
  logic        mul_req_ready, div_req_ready;
  logic        mul_resp_valid, div_resp_valid;
  logic [63:0] mul_resp_value, div_resp_value;

  // Low two bits carry the unit-local operation
  assign is_div = req_op_i[2];
  assign mul_op = mdu_pkg::mul_op_e'(req_op_i[1:0]);
  assign div_op = mdu_pkg::div_op_e'(req_op_i[1:0]);

  // Only one operation in flight across both units
  assign req_ready_o   = mul_req_ready & div_req_ready;
  assign mul_req_valid = req_valid_i & req_ready_o & ~is_div;
  assign div_req_valid = req_valid_i & req_ready_o & is_div;

  mdu_mul_fast u_mul (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (mul_op),
    .req_word_i   (req_word_i),
    .req_valid_i  (mul_req_valid),
    .req_ready_o  (mul_req_ready),
    .resp_valid_o (mul_resp_valid),
    .resp_value_o (mul_resp_value)
  );

  mdu_div u_div (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (div_op),
    .req_word_i   (req_word_i),
    .req_valid_i  (div_req_valid),
    .req_ready_o  (div_req_ready),
    .resp_valid_o (div_resp_valid),
    .resp_value_o (div_resp_value)
  );

  assign resp_valid_o = mul_resp_valid | div_resp_valid;
  assign resp_value_o = div_resp_valid ? div_resp_value : mul_resp_value;

endmodule

`default_nettype wire
